//--- src/periph_pkg.sv
`default_nettype none

package periph_pkg;

  // Bus widths
  localparam int APB_ADDR_WIDTH   = 32;
  localparam int APB_DATA_WIDTH   = 32;
  localparam int REG_OFFSET_WIDTH = 12;  // One 4 KB window per slave

  // Memory map
  localparam logic [APB_ADDR_WIDTH-1:0] GPIO_BASE  = 32'h1A10_1000;
  localparam logic [APB_ADDR_WIDTH-1:0] EVENT_BASE = 32'h1A10_4000;

  // GPIO register offsets
  localparam logic [REG_OFFSET_WIDTH-1:0] GPIO_DIR_OFF     = 12'h000;
  localparam logic [REG_OFFSET_WIDTH-1:0] GPIO_IN_OFF      = 12'h004;  // Synchronised pins
  localparam logic [REG_OFFSET_WIDTH-1:0] GPIO_OUT_OFF     = 12'h008;
  localparam logic [REG_OFFSET_WIDTH-1:0] GPIO_INTEN_OFF   = 12'h00C;  // Rising edge enable
  localparam logic [REG_OFFSET_WIDTH-1:0] GPIO_INTSTAT_OFF = 12'h010;  // Write 1 to clear

  // Event unit register offsets
  localparam logic [REG_OFFSET_WIDTH-1:0] EV_MASK_OFF      = 12'h000;
  localparam logic [REG_OFFSET_WIDTH-1:0] EV_PENDING_OFF   = 12'h004;
  localparam logic [REG_OFFSET_WIDTH-1:0] EV_CLEAR_OFF     = 12'h008;  // Write 1 to clear
  localparam logic [REG_OFFSET_WIDTH-1:0] EV_CORE_CTRL_OFF = 12'h00C;  // Bit 0 fetch enable

  // Interrupt line numbers
  localparam int EXT_EVENT_LINE  = 24;  // Former UART position
  localparam int GPIO_EVENT_LINE = 25;

  // APB request from the bridge
  typedef struct packed {
    logic                      sel;
    logic                      enable;
    logic                      write;
    logic [APB_ADDR_WIDTH-1:0] addr;
    logic [APB_DATA_WIDTH-1:0] wdata;
  } apb_req_t;

  // APB response back to the bridge
  typedef struct packed {
    logic [APB_DATA_WIDTH-1:0] rdata;
    logic                      ready;
    logic                      slverr;
  } apb_rsp_t;

  // Decoded access for one slave
  typedef struct packed {
    logic                        wr_en;   // Access cycle of a write only
    logic [REG_OFFSET_WIDTH-1:0] offset;
    logic [APB_DATA_WIDTH-1:0]   wdata;
  } reg_access_t;

  // Interrupt request towards the core
  typedef struct packed {
    logic       req;
    logic [4:0] id;
  } irq_req_t;

endpackage

`default_nettype wire

//--- src/apb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module apb_decoder (
  input  var periph_pkg::apb_req_t    apb_req_i,
  output periph_pkg::apb_rsp_t        apb_rsp_o,
  output periph_pkg::reg_access_t     gpio_acc_o,
  output periph_pkg::reg_access_t     event_acc_o,
  input  wire [periph_pkg::APB_DATA_WIDTH-1:0] gpio_rdata_i,
  input  wire [periph_pkg::APB_DATA_WIDTH-1:0] event_rdata_i
);

  localparam int AW = periph_pkg::APB_ADDR_WIDTH;
  localparam int OW = periph_pkg::REG_OFFSET_WIDTH;

  logic          gpio_hit;
  logic          event_hit;
  logic          access;     // Second cycle of a transfer
  logic          wr_access;
  logic [AW-1:OW] page;

  // Window match on the page number only
  assign page      = apb_req_i.addr[AW-1:OW];
  assign gpio_hit  = (page == periph_pkg::GPIO_BASE[AW-1:OW]);
  assign event_hit = (page == periph_pkg::EVENT_BASE[AW-1:OW]);

  assign access    = apb_req_i.sel & apb_req_i.enable;
  assign wr_access = access & apb_req_i.write;

  // Per-slave requests
  always_comb
  begin
    gpio_acc_o.wr_en  = wr_access & gpio_hit;
    gpio_acc_o.offset = apb_req_i.addr[OW-1:0];
    gpio_acc_o.wdata  = apb_req_i.wdata;

    event_acc_o.wr_en  = wr_access & event_hit;
    event_acc_o.offset = apb_req_i.addr[OW-1:0];
    event_acc_o.wdata  = apb_req_i.wdata;
  end

  // Response mux, zero on a miss
  always_comb
  begin
    if (gpio_hit)
    begin
      apb_rsp_o.rdata = gpio_rdata_i;
    end
    else if (event_hit)
    begin
      apb_rsp_o.rdata = event_rdata_i;
    end
    else
    begin
      apb_rsp_o.rdata = '0;
    end

    apb_rsp_o.ready  = 1'b1;  // No wait states
    apb_rsp_o.slverr = access & ~(gpio_hit | event_hit);
  end

endmodule

`default_nettype wire

//--- src/gpio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_regs #(
  parameter int NUM_GPIO = 32
) (
  input  wire                                  clock,
  input  wire                                  reset_n_sync,
  input  var periph_pkg::reg_access_t          acc_i,
  output logic [periph_pkg::APB_DATA_WIDTH-1:0] rdata_o,
  input  wire  [NUM_GPIO-1:0]                  gpio_i,
  output logic [NUM_GPIO-1:0]                  gpio_out_o,
  output logic [NUM_GPIO-1:0]                  gpio_dir_o,
  output logic                                 event_o
);

  logic [NUM_GPIO-1:0] dir_q;
  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] inten_q;
  logic [NUM_GPIO-1:0] intstat_q;
  logic [NUM_GPIO-1:0] sync1_q;
  logic [NUM_GPIO-1:0] sync2_q;   // Pin value seen by software
  logic [NUM_GPIO-1:0] prev_q;
  logic [NUM_GPIO-1:0] rise;
  logic [NUM_GPIO-1:0] wdata;
  logic [NUM_GPIO-1:0] stat_clr;

  assign wdata = acc_i.wdata[NUM_GPIO-1:0];

  // Enabled rising edges only
  assign rise = sync2_q & ~prev_q & inten_q;

  always_comb
  begin
    stat_clr = '0;
    if (acc_i.wr_en && acc_i.offset == periph_pkg::GPIO_INTSTAT_OFF)
    begin
      stat_clr = wdata;
    end
  end

  // Input synchroniser and edge history
  always_ff @(posedge clock or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end
    else
    begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // Software registers
  always_ff @(posedge clock or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      dir_q     <= '0;
      out_q     <= '0;
      inten_q   <= '0;
      intstat_q <= '0;
    end
    else
    begin
      if (acc_i.wr_en && acc_i.offset == periph_pkg::GPIO_DIR_OFF)
        dir_q <= wdata;
      if (acc_i.wr_en && acc_i.offset == periph_pkg::GPIO_OUT_OFF)
        out_q <= wdata;
      if (acc_i.wr_en && acc_i.offset == periph_pkg::GPIO_INTEN_OFF)
        inten_q <= wdata;
      intstat_q <= (intstat_q & ~stat_clr) | rise;  // New edge beats clear
    end
  end

  // Read mux, upper bits stay zero
  always_comb
  begin
    rdata_o = '0;
    case (acc_i.offset)
      periph_pkg::GPIO_DIR_OFF:     rdata_o[NUM_GPIO-1:0] = dir_q;
      periph_pkg::GPIO_IN_OFF:      rdata_o[NUM_GPIO-1:0] = sync2_q;
      periph_pkg::GPIO_OUT_OFF:     rdata_o[NUM_GPIO-1:0] = out_q;
      periph_pkg::GPIO_INTEN_OFF:   rdata_o[NUM_GPIO-1:0] = inten_q;
      periph_pkg::GPIO_INTSTAT_OFF: rdata_o[NUM_GPIO-1:0] = intstat_q;
      default:                      rdata_o = '0;
    endcase
  end

  assign gpio_out_o = out_q;
  assign gpio_dir_o = dir_q;
  assign event_o    = |intstat_q;

endmodule

`default_nettype wire

//--- src/event_unit.sv
`timescale 1ns/1ps
`default_nettype none

module event_unit (
  input  wire                                   clock,
  input  wire                                   reset_n_sync,
  input  var periph_pkg::reg_access_t           acc_i,
  output logic [periph_pkg::APB_DATA_WIDTH-1:0] rdata_o,
  input  wire                                   gpio_event_i,
  input  wire                                   ext_event_i,
  input  wire                                   fetch_enable_i,
  output logic                                  fetch_enable_o,
  output periph_pkg::irq_req_t                  irq_o
);

  logic [31:0] ev_src;
  logic [31:0] ev_src_q;    // Previous source levels
  logic [31:0] ev_rise;
  logic [31:0] pending_q;
  logic [31:0] mask_q;
  logic [31:0] pend_clr;
  logic [31:0] masked;
  logic        sw_fetch_en_q;

  // Sources placed at their line numbers
  always_comb
  begin
    ev_src = '0;
    ev_src[periph_pkg::EXT_EVENT_LINE]  = ext_event_i;
    ev_src[periph_pkg::GPIO_EVENT_LINE] = gpio_event_i;
  end

  assign ev_rise = ev_src & ~ev_src_q;

  always_comb
  begin
    pend_clr = '0;
    if (acc_i.wr_en && acc_i.offset == periph_pkg::EV_CLEAR_OFF)
    begin
      pend_clr = acc_i.wdata;
    end
  end

  always_ff @(posedge clock or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      ev_src_q      <= '0;
      pending_q     <= '0;
      mask_q        <= '0;
      sw_fetch_en_q <= 1'b0;
    end
    else
    begin
      ev_src_q  <= ev_src;
      pending_q <= (pending_q & ~pend_clr) | ev_rise;  // Set wins over clear
      if (acc_i.wr_en && acc_i.offset == periph_pkg::EV_MASK_OFF)
        mask_q <= acc_i.wdata;
      if (acc_i.wr_en && acc_i.offset == periph_pkg::EV_CORE_CTRL_OFF)
        sw_fetch_en_q <= acc_i.wdata[0];
    end
  end

  // Highest masked line wins
  assign masked = pending_q & mask_q;

  always_comb
  begin
    irq_o.req = |masked;
    irq_o.id  = '0;
    for (int i = 0; i < 32; i++)
    begin
      if (masked[i])
        irq_o.id = i[4:0];
    end
  end

  always_comb
  begin
    case (acc_i.offset)
      periph_pkg::EV_MASK_OFF:      rdata_o = mask_q;
      periph_pkg::EV_PENDING_OFF:   rdata_o = pending_q;
      periph_pkg::EV_CORE_CTRL_OFF: rdata_o = {31'b0, sw_fetch_en_q};
      default:                      rdata_o = '0;  // Clear reads back zero
    endcase
  end

  assign fetch_enable_o = fetch_enable_i | sw_fetch_en_q;

endmodule

`default_nettype wire

//--- src/periph_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem #(
  parameter int NUM_GPIO = 32
) (
  input  wire                         clock,
  input  wire                         reset_n_sync,
  input  var periph_pkg::apb_req_t    apb_req_i,
  output periph_pkg::apb_rsp_t        apb_rsp_o,
  input  wire  [NUM_GPIO-1:0]         gpio_i,
  output logic [NUM_GPIO-1:0]         gpio_out_o,
  output logic [NUM_GPIO-1:0]         gpio_dir_o,
  input  wire                         ext_event_i,
  input  wire                         fetch_enable_i,
  output logic                        fetch_enable_o,
  output periph_pkg::irq_req_t        irq_o
);

  periph_pkg::reg_access_t                gpio_acc;
  periph_pkg::reg_access_t                event_acc;
  logic [periph_pkg::APB_DATA_WIDTH-1:0]  gpio_rdata;
  logic [periph_pkg::APB_DATA_WIDTH-1:0]  event_rdata;
  logic                                   gpio_event;   // GPIO interrupt level

  apb_decoder u_apb_decoder (
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .gpio_acc_o    (gpio_acc),
    .event_acc_o   (event_acc),
    .gpio_rdata_i  (gpio_rdata),
    .event_rdata_i (event_rdata)
  );

  gpio_regs #(
    .NUM_GPIO (NUM_GPIO)
  ) u_gpio_regs (
    .clock        (clock),
    .reset_n_sync (reset_n_sync),
    .acc_i        (gpio_acc),
    .rdata_o      (gpio_rdata),
    .gpio_i       (gpio_i),
    .gpio_out_o   (gpio_out_o),
    .gpio_dir_o   (gpio_dir_o),
    .event_o      (gpio_event)
  );

  event_unit u_event_unit (
    .clock          (clock),
    .reset_n_sync   (reset_n_sync),
    .acc_i          (event_acc),
    .rdata_o        (event_rdata),
    .gpio_event_i   (gpio_event),
    .ext_event_i    (ext_event_i),
    .fetch_enable_i (fetch_enable_i),
    .fetch_enable_o (fetch_enable_o),
    .irq_o          (irq_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clock_o,
  output logic reset_n_o
);

  initial
  begin
    clock_o = 1'b0;
    forever #(PERIOD_NS / 2) clock_o = ~clock_o;
  end

  // Release just after an edge
  initial
  begin
    reset_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_o);
    #1 reset_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/periph_chk.sv
`timescale 1ns/1ps
`default_nettype none

module periph_chk (
  input wire                      clock,
  input wire                      reset_n_sync,
  input var periph_pkg::apb_req_t apb_req_i,
  input var periph_pkg::apb_rsp_t apb_rsp_i,
  input wire                      fetch_enable_i,
  input wire                      fetch_en_out_i,
  input var periph_pkg::irq_req_t irq_i,
  input wire [31:0]               mask_i
);

  int fail_count = 0;  // Read by the testbench at the end

  // Only an unmasked line may request
  irq_masked_a: assert property (@(posedge clock) disable iff (!reset_n_sync)
    irq_i.req |-> mask_i[irq_i.id])
  else
  begin
    $error("irq_o.req raised on masked line %0d", irq_i.id);
    fail_count++;
  end

  slverr_access_a: assert property (@(posedge clock) disable iff (!reset_n_sync)
    apb_rsp_i.slverr |-> apb_req_i.enable)
  else
  begin
    $error("slverr outside the access cycle");
    fail_count++;
  end

  fetch_enable_a: assert property (@(posedge clock) disable iff (!reset_n_sync)
    fetch_enable_i |-> fetch_en_out_i)
  else
  begin
    $error("fetch_enable_o low while fetch_enable_i high");
    fail_count++;
  end

endmodule

bind periph_subsystem periph_chk u_chk (
  .clock          (clock),
  .reset_n_sync   (reset_n_sync),
  .apb_req_i      (apb_req_i),
  .apb_rsp_i      (apb_rsp_o),
  .fetch_enable_i (fetch_enable_i),
  .fetch_en_out_i (fetch_enable_o),
  .irq_i          (irq_o),
  .mask_i         (u_event_unit.mask_q)
);

`default_nettype wire

//--- tb/tb_periph_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsystem;

  localparam int NUM_GPIO        = 32;
  localparam int CLK_PERIOD_NS   = 8;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 60;
  localparam int SEED            = 11355;
  localparam logic [31:0] PIN_MASK = 32'hFFFF_FFFF >> (32 - NUM_GPIO);
  localparam logic [31:0] GPIO     = periph_pkg::GPIO_BASE;
  localparam logic [31:0] EV       = periph_pkg::EVENT_BASE;
  localparam logic [31:0] BAD_ADDR = 32'h1A10_2000;  // Between the two windows

  logic                 clock;
  logic                 reset_n_sync;
  periph_pkg::apb_req_t apb_req;
  periph_pkg::apb_rsp_t apb_rsp;
  logic [NUM_GPIO-1:0]  gpio_in;
  logic [NUM_GPIO-1:0]  gpio_out;
  logic [NUM_GPIO-1:0]  gpio_dir;
  logic                 ext_event;
  logic                 fetch_en_in;
  logic                 fetch_en_out;
  periph_pkg::irq_req_t irq;
  int                   errors;
  int                   tests_run;
  int                   tests_failed;
  logic [31:0]          out_val;  // Last value written to OUT, masked

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (4)
  ) u_clock_gen (
    .clock_o   (clock),
    .reset_n_o (reset_n_sync)
  );

  periph_subsystem #(
    .NUM_GPIO (NUM_GPIO)
  ) u_dut (
    .clock          (clock),
    .reset_n_sync   (reset_n_sync),
    .apb_req_i      (apb_req),
    .apb_rsp_o      (apb_rsp),
    .gpio_i         (gpio_in),
    .gpio_out_o     (gpio_out),
    .gpio_dir_o     (gpio_dir),
    .ext_event_i    (ext_event),
    .fetch_enable_i (fetch_en_in),
    .fetch_enable_o (fetch_en_out),
    .irq_o          (irq)
  );

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s at %0t", msg, $time);
    errors++;
  endtask

  // Setup and access cycle, response taken mid access cycle
  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
    apb_req.sel    = 1'b1;
    apb_req.enable = 1'b0;
    apb_req.write  = write;
    apb_req.addr   = addr;
    apb_req.wdata  = wdata;
    next_cycle();
    apb_req.enable = 1'b1;
    @(negedge clock);
    rdata  = apb_rsp.rdata;
    slverr = apb_rsp.slverr;
    if (apb_rsp.ready !== 1'b1)
      report_failure("ready was low in the access cycle");
    next_cycle();
    apb_req.sel    = 1'b0;
    apb_req.enable = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        slverr;
    apb_transfer(1'b1, addr, wdata, rdata, slverr);
    if (slverr !== 1'b0)
      report_mismatch("apb_rsp_o.slverr", 32'(slverr), 32'h0);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata);
    logic slverr;
    apb_transfer(1'b0, addr, 32'h0, rdata, slverr);
    if (slverr !== 1'b0)
      report_mismatch("apb_rsp_o.slverr", 32'(slverr), 32'h0);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp,
                             input string reg_name);
    logic [31:0] rdata;
    apb_read(addr, rdata);
    if (rdata !== exp)
      report_mismatch({"apb_rsp_o.rdata of ", reg_name}, rdata, exp);
  endtask

  // Polls for a request on the given line
  task automatic wait_for_irq(input int line, input int max_cycles);
    int n;
    n = 0;
    while (!(irq.req === 1'b1 && irq.id === 5'(line)) && n < max_cycles)
    begin
      next_cycle();
      n++;
    end
    if (!(irq.req === 1'b1 && irq.id === 5'(line)))
      report_failure($sformatf("no interrupt on line %0d within %0d cycles", line, max_cycles));
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
    begin
      $display("[%0t] %s: ok", $time, name);
    end
    else
    begin
      tests_failed++;
      $display("[%0t] %s: %0d errors", $time, name, errors - errors_before);
    end
  endtask

  task automatic test_gpio_pads();
    int          err0;
    logic [31:0] dir_val;
    err0    = errors;
    dir_val = $urandom & PIN_MASK;
    out_val = $urandom & PIN_MASK;
    apb_write(GPIO + periph_pkg::GPIO_DIR_OFF, dir_val);
    apb_write(GPIO + periph_pkg::GPIO_OUT_OFF, out_val);
    read_expect(GPIO + periph_pkg::GPIO_DIR_OFF, dir_val, "GPIO_DIR");
    read_expect(GPIO + periph_pkg::GPIO_OUT_OFF, out_val, "GPIO_OUT");
    if (32'(gpio_dir) !== dir_val)
      report_mismatch("gpio_dir_o", 32'(gpio_dir), dir_val);
    if (32'(gpio_out) !== out_val)
      report_mismatch("gpio_out_o", 32'(gpio_out), out_val);
    finish_test("gpio pads", err0);
  endtask

  task automatic test_gpio_input();
    int          err0;
    logic [31:0] pins;
    err0    = errors;
    pins    = $urandom & PIN_MASK;
    gpio_in = pins[NUM_GPIO-1:0];
    repeat (3) next_cycle();  // Two synchroniser stages plus margin
    read_expect(GPIO + periph_pkg::GPIO_IN_OFF, pins, "GPIO_IN");
    read_expect(GPIO + 32'h20, 32'h0, "unused GPIO offset");
    finish_test("gpio input", err0);
  endtask

  task automatic test_decode_error();
    int          err0;
    logic [31:0] rdata;
    logic        slverr;
    err0 = errors;
    apb_transfer(1'b1, BAD_ADDR, $urandom, rdata, slverr);
    if (slverr !== 1'b1)
      report_mismatch("apb_rsp_o.slverr", 32'(slverr), 32'h1);
    // Same offset as OUT, must not reach the GPIO
    apb_transfer(1'b1, BAD_ADDR + periph_pkg::GPIO_OUT_OFF, ~out_val, rdata, slverr);
    if (slverr !== 1'b1)
      report_mismatch("apb_rsp_o.slverr", 32'(slverr), 32'h1);
    apb_transfer(1'b0, BAD_ADDR, 32'h0, rdata, slverr);
    if (slverr !== 1'b1)
      report_mismatch("apb_rsp_o.slverr", 32'(slverr), 32'h1);
    if (rdata !== 32'h0)
      report_mismatch("apb_rsp_o.rdata", rdata, 32'h0);
    read_expect(GPIO + periph_pkg::GPIO_OUT_OFF, out_val, "GPIO_OUT");
    read_expect(EV + periph_pkg::EV_MASK_OFF, 32'h0, "EV_MASK");
    finish_test("decode error", err0);
  endtask

  task automatic test_gpio_irq();
    int err0;
    err0    = errors;
    gpio_in = '0;
    apb_write(GPIO + periph_pkg::GPIO_INTEN_OFF, 32'h8);
    apb_write(EV + periph_pkg::EV_MASK_OFF, 32'h1 << periph_pkg::GPIO_EVENT_LINE);
    gpio_in[3] = 1'b1;
    wait_for_irq(periph_pkg::GPIO_EVENT_LINE, 6);
    read_expect(GPIO + periph_pkg::GPIO_INTSTAT_OFF, 32'h8, "GPIO_INTSTAT");
    read_expect(EV + periph_pkg::EV_PENDING_OFF, 32'h0200_0000, "EV_PENDING");
    apb_write(GPIO + periph_pkg::GPIO_INTSTAT_OFF, 32'h8);
    apb_write(EV + periph_pkg::EV_CLEAR_OFF, 32'h0200_0000);
    if (irq.req !== 1'b0)
      report_mismatch("irq_o.req", 32'(irq.req), 32'h0);
    finish_test("gpio interrupt", err0);
  endtask

  task automatic test_priority_mask();
    int err0;
    err0       = errors;
    gpio_in[3] = 1'b0;
    apb_write(EV + periph_pkg::EV_MASK_OFF, 32'h0300_0000);
    repeat (2) next_cycle();  // Pin history back to low
    gpio_in[3] = 1'b1;
    ext_event  = 1'b1;
    next_cycle();
    ext_event = 1'b0;
    wait_for_irq(periph_pkg::GPIO_EVENT_LINE, 6);
    apb_write(EV + periph_pkg::EV_MASK_OFF, 32'h0100_0000);
    if (irq.req !== 1'b1)
      report_mismatch("irq_o.req", 32'(irq.req), 32'h1);
    if (irq.id !== 5'd24)
      report_mismatch("irq_o.id", 32'(irq.id), 32'd24);
    apb_write(EV + periph_pkg::EV_MASK_OFF, 32'h0);
    if (irq.req !== 1'b0)
      report_mismatch("irq_o.req", 32'(irq.req), 32'h0);
    read_expect(EV + periph_pkg::EV_PENDING_OFF, 32'h0300_0000, "EV_PENDING");
    finish_test("priority and mask", err0);
  endtask

  task automatic test_fetch_enable();
    int err0;
    err0 = errors;
    if (fetch_en_out !== 1'b0)
      report_mismatch("fetch_enable_o", 32'(fetch_en_out), 32'h0);
    apb_write(EV + periph_pkg::EV_CORE_CTRL_OFF, 32'h1);
    if (fetch_en_out !== 1'b1)
      report_mismatch("fetch_enable_o", 32'(fetch_en_out), 32'h1);
    read_expect(EV + periph_pkg::EV_CORE_CTRL_OFF, 32'h1, "EV_CORE_CTRL");
    apb_write(EV + periph_pkg::EV_CORE_CTRL_OFF, 32'h0);
    if (fetch_en_out !== 1'b0)
      report_mismatch("fetch_enable_o", 32'(fetch_en_out), 32'h0);
    fetch_en_in = 1'b1;
    next_cycle();
    if (fetch_en_out !== 1'b1)
      report_mismatch("fetch_enable_o", 32'(fetch_en_out), 32'h1);
    finish_test("fetch enable", err0);
  endtask

  initial
  begin
    void'($urandom(SEED));
    apb_req      = '0;
    gpio_in      = '0;
    ext_event    = 1'b0;
    fetch_en_in  = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    out_val      = '0;
    wait (reset_n_sync === 1'b1);
    next_cycle();
    test_gpio_pads();
    test_gpio_input();
    test_decode_error();
    test_gpio_irq();
    test_priority_mask();
    test_fetch_enable();
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, u_dut.u_chk.fail_count);
    if (errors == 0 && tests_failed == 0 && u_dut.u_chk.fail_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Budget per test, well above the longest one
  initial
  begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD_NS);
    $display("Watchdog expired, the tests did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
src/periph_pkg.sv
src/apb_decoder.sv
src/gpio_regs.sv
src/event_unit.sv
src/periph_subsystem.sv
tb/tb_clock_gen.sv
tb/periph_chk.sv
tb/tb_periph_subsystem.sv
